/* project.f */
hw/i2c_pkg.sv
hw/i2c_bit_ctl.sv
hw/i2c_byte_ctl.sv
hw/i2c_master_top.sv
tests/i2c_slave_model.sv
tests/i2c_checker.sv
tests/tb_i2c_master.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_i2c_master
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/tb_i2c_master.sv */
`timescale 1ns/1ps

module tb_i2c_master import i2c_pkg::*; ();

localparam logic [6:0] slave_addr = 7'h2a;

logic         sysclk;
logic         nReset;
logic         enable;
prescale_t    prescale;
byte_cmd_t    cmd;
logic         done;
byte_status_t status;
logic         scl_o;
logic         scl_oen;
logic         sda_o;
logic         sda_oen;
logic         scl;
logic         sda;
logic         arb_en;
logic         exp_valid;
byte_status_t exp_status;
byte_status_t exp_mask;
int           chk_errors;
int           checks;
int           tb_errors;
int           seed_dummy;
int           n;
logic         bus_busy;     // expected bus state
logic [3:0]   rd_idx;
logic [3:0]   k;
i2c_byte_t    wr_bytes [0:3];
byte_cmd_t    arb_cmd;
byte_status_t arb_exp;

i2c_master_top u_i2c_master_top (
    .sysclk   (sysclk),
    .nReset   (nReset),
    .enable   (enable),
    .prescale (prescale),
    .cmd      (cmd),
    .done     (done),
    .status   (status),
    .scl_i    (scl),
    .scl_o    (scl_o),
    .scl_oen  (scl_oen),
    .sda_i    (sda),
    .sda_o    (sda_o),
    .sda_oen  (sda_oen)
);

i2c_slave_model #(.addr(slave_addr)) u_slave (
    .scl_oen (scl_oen),
    .sda_oen (sda_oen),
    .arb_en  (arb_en),
    .scl     (scl),
    .sda     (sda)
);

i2c_checker u_checker (
    .sysclk     (sysclk),
    .nReset     (nReset),
    .done       (done),
    .status     (status),
    .scl_o      (scl_o),
    .sda_o      (sda_o),
    .exp_valid  (exp_valid),
    .exp_status (exp_status),
    .exp_mask   (exp_mask),
    .errors     (chk_errors),
    .checks     (checks)
);

initial
begin
    sysclk = 1'b0;
    forever #5 sysclk = ~sysclk;
end

// expected status from the command and what the slave holds
function automatic byte_status_t expect_status(byte_cmd_t c, logic slave_ack,
                                               i2c_byte_t rd_byte, logic busy_before);
    byte_status_t s;
    s.ack_out = c.read ? c.ack_in : ~slave_ack;
    s.rxd     = c.read ? rd_byte : c.txd;    // writes read back their own bits
    s.busy    = c.stop ? 1'b0 : (c.start ? 1'b1 : busy_before);
    s.arblost = 1'b0;
    return s;
endfunction

task automatic check_value(string name, logic [7:0] got, logic [7:0] exp);
    if (got !== exp)
    begin
        $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
        tb_errors = tb_errors + 1;
    end
endtask

task automatic run_cmd(byte_cmd_t c, byte_status_t exp, byte_status_t mask);
    int cycles;
    exp_status = exp;
    exp_mask   = mask;
    exp_valid  = 1'b1;
    cmd        = c;
    cycles     = 0;
    while (!done && cycles < 5000)
    begin
        @(posedge sysclk);
        #1;
        cycles = cycles + 1;
    end
    if (!done)
    begin
        $display("timeout: command %h got no done within 5000 cycles", c);
        tb_errors = tb_errors + 1;
    end
    cmd = '0;
    @(posedge sysclk);
    #1;
    exp_valid = 1'b0;
endtask

task automatic send_write(i2c_byte_t b, logic start, logic stop, logic acks);
    byte_cmd_t    c;
    byte_status_t e;
    c = '{start: start, stop: stop, read: 1'b0, write: 1'b1, ack_in: 1'b0, txd: b};
    e = expect_status(c, acks, 8'h00, bus_busy);
    run_cmd(c, e, '1);
    bus_busy = e.busy;
endtask

task automatic send_read(logic ack_in, logic stop);
    byte_cmd_t    c;
    byte_status_t e;
    c = '{start: 1'b0, stop: stop, read: 1'b1, write: 1'b0, ack_in: ack_in, txd: 8'h00};
    e = expect_status(c, 1'b1, u_slave.rd_mem[rd_idx], bus_busy);
    rd_idx = rd_idx + 1'b1;
    run_cmd(c, e, '1);
    bus_busy = e.busy;
endtask

initial
begin
    seed_dummy = $urandom(32'hf190da3d);
    nReset     = 1'b0;
    enable     = 1'b0;
    prescale   = 16'd16;
    cmd        = '0;
    arb_en     = 1'b0;
    exp_valid  = 1'b0;
    exp_status = '0;
    exp_mask   = '0;
    tb_errors  = 0;
    bus_busy   = 1'b0;
    rd_idx     = '0;
    for (k = 0; k < 4'd15; k++)
        u_slave.rd_mem[k] = i2c_byte_t'($urandom);
    repeat (5) @(posedge sysclk);
    #1;
    nReset = 1'b1;
    enable = 1'b1;
    check_value("done", {7'b0, done}, 8'h00);
    check_value("scl_oen", {7'b0, scl_oen}, 8'h01);
    check_value("sda_oen", {7'b0, sda_oen}, 8'h01);
    check_value("status.busy", {7'b0, status.busy}, 8'h00);
    check_value("status.arblost", {7'b0, status.arblost}, 8'h00);

    // address then data bytes, busy until the stop
    send_write({slave_addr, 1'b0}, 1'b1, 1'b0, 1'b1);
    for (k = 0; k < 4'd4; k++)
    begin
        wr_bytes[k[1:0]] = i2c_byte_t'($urandom);
        send_write(wr_bytes[k[1:0]], 1'b0, k == 4'd3, 1'b1);
    end
    check_value("wr_count", {4'b0, u_slave.wr_count}, 8'h04);
    for (k = 0; k < 4'd4; k++)
        check_value("wr_log", u_slave.wr_log[k], wr_bytes[k[1:0]]);

    // repeated start into three reads
    send_write({slave_addr, 1'b0}, 1'b1, 1'b0, 1'b1);
    send_write({slave_addr, 1'b1}, 1'b1, 1'b0, 1'b1);
    send_read(1'b0, 1'b0);
    send_read(1'b0, 1'b0);
    send_read(1'b1, 1'b1);
    check_value("mack_log[0]", {7'b0, u_slave.mack_log[0]}, 8'h00);
    check_value("mack_log[1]", {7'b0, u_slave.mack_log[1]}, 8'h00);
    check_value("mack_log[2]", {7'b0, u_slave.mack_log[2]}, 8'h01);

    send_write({7'h3c, 1'b0}, 1'b1, 1'b1, 1'b0);    // nobody home

    // slave holds sda low against a 1
    arb_en  = 1'b1;
    arb_cmd = '{start: 1'b1, stop: 1'b0, read: 1'b0, write: 1'b1, ack_in: 1'b0, txd: 8'hff};
    arb_exp = '0;
    arb_exp.arblost = 1'b1;
    run_cmd(arb_cmd, arb_exp, arb_exp);
    arb_en = 1'b0;
    enable = 1'b0;
    repeat (4) @(posedge sysclk);
    #1;
    enable   = 1'b1;
    bus_busy = 1'b0;
    send_write({slave_addr, 1'b0}, 1'b1, 1'b0, 1'b1);
    send_write(i2c_byte_t'($urandom), 1'b0, 1'b1, 1'b1);

    // enable dropped in the middle of the address byte
    cmd = '{start: 1'b1, stop: 1'b0, read: 1'b0, write: 1'b1, ack_in: 1'b0,
            txd: {slave_addr, 1'b0}};
    n = 0;
    while (u_slave.bit_cnt < 3 && n < 5000)
    begin
        @(posedge sysclk);
        #1;
        n = n + 1;
    end
    if (u_slave.bit_cnt < 3)
    begin
        $display("timeout: slave saw no address bits after enable test start");
        tb_errors = tb_errors + 1;
    end
    enable = 1'b0;
    cmd    = '0;
    repeat (2) @(posedge sysclk);
    #1;
    check_value("scl_oen", {7'b0, scl_oen}, 8'h01);
    check_value("sda_oen", {7'b0, sda_oen}, 8'h01);
    repeat (20) @(posedge sysclk);    // checker flags any done here
    #1;
    enable   = 1'b1;
    bus_busy = 1'b0;
    send_write({slave_addr, 1'b0}, 1'b1, 1'b0, 1'b1);
    send_write(i2c_byte_t'($urandom), 1'b0, 1'b1, 1'b1);

    repeat (4) @(posedge sysclk);
    $display("errors: checker %0d, testbench %0d, status checks %0d",
             chk_errors, tb_errors, checks);
    if (chk_errors == 0 && tb_errors == 0)
        $display("STATUS: PASS");
    else
        $display("STATUS: FAIL");
    $finish;
end

endmodule

/* tests/i2c_checker.sv */
`timescale 1ns/1ps

module i2c_checker import i2c_pkg::*; (
    input  logic         sysclk,
    input  logic         nReset,
    input  logic         done,
    input  byte_status_t status,
    input  logic         scl_o,
    input  logic         sda_o,
    input  logic         exp_valid,
    input  byte_status_t exp_status,
    input  byte_status_t exp_mask,    // fields that count
    output int           errors,
    output int           checks
);

int err_cnt = 0;
int chk_cnt = 0;

assign errors = err_cnt;
assign checks = chk_cnt;

task automatic report_mismatch(string name, logic [7:0] got, logic [7:0] exp);
    if (got !== exp)
    begin
        $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
        err_cnt = err_cnt + 1;
    end
endtask

// mid cycle, done and status are settled
always @(negedge sysclk)
begin
    if (nReset)
    begin
        report_mismatch("scl_o", {7'b0, scl_o}, 8'h00);    // open drain, never driven high
        report_mismatch("sda_o", {7'b0, sda_o}, 8'h00);
    end
    if (nReset && done && !exp_valid)
    begin
        $display("done pulsed while no command was pending at %0t", $time);
        err_cnt = err_cnt + 1;
    end
    else if (nReset && done)
    begin
        chk_cnt = chk_cnt + 1;
        if (exp_mask.ack_out)
            report_mismatch("status.ack_out", {7'b0, status.ack_out}, {7'b0, exp_status.ack_out});
        if (exp_mask.rxd != '0)
            report_mismatch("status.rxd", status.rxd, exp_status.rxd);
        if (exp_mask.busy)
            report_mismatch("status.busy", {7'b0, status.busy}, {7'b0, exp_status.busy});
        if (exp_mask.arblost)
            report_mismatch("status.arblost", {7'b0, status.arblost},
                            {7'b0, exp_status.arblost});
    end
end

endmodule

/* tests/i2c_slave_model.sv */
`timescale 1ns/1ps

module i2c_slave_model import i2c_pkg::*; #(
    parameter logic [6:0] addr = 7'h2a
) (
    input  logic scl_oen,
    input  logic sda_oen,
    input  logic arb_en,     // steal sda from the next scl fall
    output logic scl,
    output logic sda
);

typedef enum logic [2:0] {
    s_idle,
    s_addr,
    s_addr_ack,
    s_wr,
    s_wr_ack,
    s_rd,
    s_rd_ack
} slave_state_e;

slave_state_e state = s_idle;
i2c_byte_t    sr = '0;
int           bit_cnt = 0;
logic         rw = 1'b0;
logic         mack = 1'b1;
logic         ack_pull = 1'b0;
logic         arb_armed = 1'b0;
logic         scl_q = 1'b1;
logic         sda_q = 1'b1;
logic [3:0]   wr_count = '0;
logic [3:0]   rd_ptr = '0;
logic [3:0]   mack_count = '0;
i2c_byte_t    wr_log [0:15];
i2c_byte_t    rd_mem [0:15];    // filled by the testbench
logic         mack_log [0:15];

assign scl = scl_oen;    // pull-up, no stretching
assign sda = sda_oen & ~ack_pull & ~(arb_en & arb_armed);

task automatic load_read();
    sr       = rd_mem[rd_ptr];
    rd_ptr   = rd_ptr + 1'b1;
    bit_cnt  = 0;
    ack_pull = ~sr[7];
    state    = s_rd;
endtask

task automatic sample_bit();
    case (state)
        s_addr, s_wr:
        begin
            sr      = {sr[6:0], sda};
            bit_cnt = bit_cnt + 1;
        end
        s_rd:
        begin
            sr      = {sr[6:0], 1'b0};
            bit_cnt = bit_cnt + 1;
        end
        s_rd_ack:
        begin
            mack                 = sda;
            mack_log[mack_count] = sda;
            mack_count           = mack_count + 1'b1;
        end
        default:
            ;
    endcase
endtask

task automatic drive_bit();
    if (arb_en)
        arb_armed = 1'b1;
    case (state)
        s_addr:
        begin
            if (bit_cnt == 8 && sr[7:1] == addr)
            begin
                rw       = sr[0];
                ack_pull = 1'b1;
                state    = s_addr_ack;
            end
            else if (bit_cnt == 8)
                state = s_idle;    // not ours
        end
        s_addr_ack, s_wr_ack:
        begin
            if (state == s_addr_ack && rw)
                load_read();
            else
            begin
                ack_pull = 1'b0;
                bit_cnt  = 0;
                state    = s_wr;
            end
        end
        s_wr:
        begin
            if (bit_cnt == 8)
            begin
                wr_log[wr_count] = sr;
                wr_count         = wr_count + 1'b1;
                ack_pull         = 1'b1;
                state            = s_wr_ack;
            end
        end
        s_rd:
        begin
            if (bit_cnt == 8)
            begin
                ack_pull = 1'b0;
                state    = s_rd_ack;
            end
            else
                ack_pull = ~sr[7];
        end
        s_rd_ack:
        begin
            if (!mack)
                load_read();
            else
            begin
                ack_pull = 1'b0;
                state    = s_idle;
            end
        end
        default:
            ;
    endcase
endtask

always @(scl or sda or arb_en)
begin
    if (!arb_en)
        arb_armed = 1'b0;
    if (scl && scl_q && sda_q && !sda)
    begin
        state     = s_addr;    // start or repeated start
        bit_cnt   = 0;
        ack_pull  = 1'b0;
        arb_armed = 1'b0;
    end
    else if (scl && scl_q && !sda_q && sda)
    begin
        state    = s_idle;     // stop
        ack_pull = 1'b0;
    end
    else if (scl && !scl_q)
        sample_bit();
    else if (!scl && scl_q)
        drive_bit();
    scl_q = scl;
    sda_q = sda;
end

endmodule

/* hw/i2c_master_top.sv */
`timescale 1ns/1ps

module i2c_master_top import i2c_pkg::*; (
    input  logic         sysclk,
    input  logic         nReset,
    input  logic         enable,
    input  prescale_t    prescale,
    input  byte_cmd_t    cmd,
    output logic         done,
    output byte_status_t status,
    input  logic         scl_i,
    output logic         scl_o,
    output logic         scl_oen,
    input  logic         sda_i,
    output logic         sda_o,
    output logic         sda_oen
);

bit_cmd_e bit_cmd;
logic     bit_din;
logic     bit_ack;
logic     bit_dout;
logic     busy;
logic     arblost;

i2c_byte_ctl u_byte_ctl (
    .sysclk   (sysclk),
    .nReset   (nReset),
    .enable   (enable),
    .cmd      (cmd),
    .bit_ack  (bit_ack),
    .bit_dout (bit_dout),
    .busy     (busy),
    .arblost  (arblost),
    .done     (done),
    .status   (status),
    .bit_cmd  (bit_cmd),
    .bit_din  (bit_din)
);

i2c_bit_ctl u_bit_ctl (
    .sysclk   (sysclk),
    .nReset   (nReset),
    .enable   (enable),
    .prescale (prescale),
    .bit_cmd  (bit_cmd),
    .bit_din  (bit_din),
    .bit_ack  (bit_ack),
    .bit_dout (bit_dout),
    .busy     (busy),
    .arblost  (arblost),
    .scl_i    (scl_i),
    .scl_o    (scl_o),
    .scl_oen  (scl_oen),
    .sda_i    (sda_i),
    .sda_o    (sda_o),
    .sda_oen  (sda_oen)
);

endmodule

/* hw/i2c_byte_ctl.sv */
`timescale 1ns/1ps

module i2c_byte_ctl import i2c_pkg::*; (
    input  logic         sysclk,
    input  logic         nReset,
    input  logic         enable,
    input  byte_cmd_t    cmd,
    input  logic         bit_ack,
    input  logic         bit_dout,
    input  logic         busy,
    input  logic         arblost,
    output logic         done,
    output byte_status_t status,
    output bit_cmd_e     bit_cmd,
    output logic         bit_din
);

byte_state_e state;
i2c_byte_t   sr;          // txd out, rxd in
bit_cnt_t    bit_cnt;
logic        ack_out;
bit_cmd_e    data_cmd;
logic        active;

assign data_cmd = cmd.read ? cmd_read : cmd_write;
assign active   = (state == byte_start) || (state == byte_shift) ||
                  (state == byte_ack) || (state == byte_stop);

// ack slot of a read sends the host's ack bit
assign bit_din = (state == byte_ack) ? cmd.ack_in : sr[7];

assign status = '{ack_out: ack_out, rxd: sr, busy: busy, arblost: arblost};

always_ff @(posedge sysclk)
begin
    if (state == byte_idle)
        sr <= cmd.txd;
    else if (state == byte_shift && bit_ack)
        sr <= {sr[6:0], bit_dout};    // msb first
    if (state == byte_ack && bit_ack)
        ack_out <= bit_dout;
end

always_ff @(posedge sysclk or negedge nReset)
begin
    if (!nReset)
    begin
        state   <= byte_idle;
        bit_cmd <= cmd_idle;
        bit_cnt <= '0;
        done    <= 1'b0;
    end
    else if (!enable)
    begin
        state   <= byte_idle;
        bit_cmd <= cmd_idle;
        bit_cnt <= '0;
        done    <= 1'b0;
    end
    else if (arblost && active)
    begin
        state   <= byte_done;   // abort, report through status
        bit_cmd <= cmd_idle;
        done    <= 1'b1;
    end
    else
    begin
        done <= 1'b0;
        case (state)
            byte_idle:
            begin
                bit_cnt <= '1;
                if (cmd.start)
                begin
                    state   <= byte_start;
                    bit_cmd <= busy ? cmd_restart : cmd_start;
                end
                else if (cmd.read || cmd.write)
                begin
                    state   <= byte_shift;
                    bit_cmd <= data_cmd;
                end
                else if (cmd.stop)
                begin
                    state   <= byte_stop;
                    bit_cmd <= cmd_stop;
                end
            end
            byte_start:
            begin
                if (bit_ack)
                begin
                    if (cmd.read || cmd.write)
                    begin
                        state   <= byte_shift;
                        bit_cmd <= data_cmd;
                    end
                    else if (cmd.stop)
                    begin
                        state   <= byte_stop;
                        bit_cmd <= cmd_stop;
                    end
                    else
                    begin
                        state   <= byte_done;
                        bit_cmd <= cmd_idle;
                        done    <= 1'b1;
                    end
                end
            end
            byte_shift:
            begin
                if (bit_ack && bit_cnt == '0)
                begin
                    state   <= byte_ack;
                    bit_cmd <= cmd.read ? cmd_write : cmd_read;  // ack goes the other way
                end
                else if (bit_ack)
                    bit_cnt <= bit_cnt - 1'b1;
            end
            byte_ack:
            begin
                if (bit_ack && cmd.stop)
                begin
                    state   <= byte_stop;
                    bit_cmd <= cmd_stop;
                end
                else if (bit_ack)
                begin
                    state   <= byte_done;
                    bit_cmd <= cmd_idle;
                    done    <= 1'b1;
                end
            end
            byte_stop:
            begin
                if (bit_ack)
                begin
                    state   <= byte_done;
                    bit_cmd <= cmd_idle;
                    done    <= 1'b1;
                end
            end
            byte_done:
                state <= byte_idle;     // host swaps cmd here
            default:
                state <= byte_idle;
        endcase
    end
end

endmodule

/* hw/i2c_bit_ctl.sv */
`timescale 1ns/1ps

module i2c_bit_ctl import i2c_pkg::*; (
    input  logic      sysclk,
    input  logic      nReset,
    input  logic      enable,
    input  prescale_t prescale,
    input  bit_cmd_e  bit_cmd,
    input  logic      bit_din,
    output logic      bit_ack,
    output logic      bit_dout,
    output logic      busy,
    output logic      arblost,
    input  logic      scl_i,
    output logic      scl_o,
    output logic      scl_oen,
    input  logic      sda_i,
    output logic      sda_o,
    output logic      sda_oen
);

bit_state_e state;
prescale_t  cnt;
logic       clk_en;
logic       sda_chk;       // master drives data, compare bus
logic [1:0] scl_sync;
logic [1:0] sda_sync;
logic       sda_d;
logic       scl_s;
logic       sda_s;
logic       sta_det;
logic       sto_det;
logic       al_det;

assign scl_s   = scl_sync[1];
assign sda_s   = sda_sync[1];
assign sta_det = scl_s & sda_d & ~sda_s;    // sda falls, scl high
assign sto_det = scl_s & ~sda_d & sda_s;
assign al_det  = sda_chk & sda_oen & ~sda_s;

assign scl_o = 1'b0;   // open drain
assign sda_o = 1'b0;

always_ff @(posedge sysclk or negedge nReset)
begin
    if (!nReset)
    begin
        cnt    <= prescale_reset;
        clk_en <= 1'b1;
    end
    else if (!enable)
    begin
        cnt    <= prescale >> 2;
        clk_en <= 1'b1;
    end
    else if (cnt == '0)
    begin
        cnt    <= (state == bit_idle) ? (prescale >> 4) : (prescale >> 2);
        clk_en <= 1'b1;
    end
    else
    begin
        cnt    <= cnt - 1'b1;
        clk_en <= 1'b0;
    end
end

always_ff @(posedge sysclk or negedge nReset)
begin
    if (!nReset)
    begin
        scl_sync <= 2'b11;
        sda_sync <= 2'b11;
        sda_d    <= 1'b1;
    end
    else
    begin
        scl_sync <= {scl_sync[0], scl_i};
        sda_sync <= {sda_sync[0], sda_i};
        sda_d    <= sda_sync[1];
    end
end

// sample in the middle of scl high
always_ff @(posedge sysclk)
begin
    if (clk_en && (state == bit_read_c || state == bit_write_c))
        bit_dout <= sda_s;
end

always_ff @(posedge sysclk or negedge nReset)
begin
    if (!nReset)
    begin
        state   <= bit_idle;
        scl_oen <= 1'b1;
        sda_oen <= 1'b1;
        sda_chk <= 1'b0;
        bit_ack <= 1'b0;
        busy    <= 1'b0;
        arblost <= 1'b0;
    end
    else if (!enable)
    begin
        state   <= bit_idle;
        scl_oen <= 1'b1;
        sda_oen <= 1'b1;
        sda_chk <= 1'b0;
        bit_ack <= 1'b0;
        busy    <= 1'b0;
        arblost <= 1'b0;
    end
    else
    begin
        bit_ack <= 1'b0;
        if (sta_det)
            busy <= 1'b1;
        else if (sto_det)
            busy <= 1'b0;

        if (al_det)
        begin
            arblost <= 1'b1;    // held until enable drops
            state   <= bit_idle;
            scl_oen <= 1'b1;
            sda_oen <= 1'b1;
            sda_chk <= 1'b0;
        end
        else if (clk_en)
        begin
            sda_chk <= 1'b0;
            case (state)
                bit_idle:
                begin
                    if (!bit_ack && !arblost)   // old cmd still up during ack
                    begin
                        case (bit_cmd)
                            cmd_start:   state <= bit_start_a;
                            cmd_stop:    state <= bit_stop_a;
                            cmd_write:   state <= bit_write_a;
                            cmd_read:    state <= bit_read_a;
                            cmd_restart: state <= bit_restart_a;
                            default:     state <= bit_idle;
                        endcase
                    end
                end
                bit_start_a:
                begin
                    state   <= bit_start_b;
                    sda_oen <= 1'b1;
                end
                bit_start_b:
                begin
                    state   <= bit_start_c;
                    scl_oen <= 1'b1;
                    sda_oen <= 1'b1;
                end
                bit_start_c:
                begin
                    state   <= bit_start_d;
                    sda_oen <= 1'b0;    // start condition
                end
                bit_start_d:
                    state <= bit_start_e;
                bit_start_e:
                begin
                    state   <= bit_idle;
                    scl_oen <= 1'b0;
                    bit_ack <= 1'b1;
                end
                bit_stop_a:
                begin
                    state   <= bit_stop_b;
                    scl_oen <= 1'b0;
                    sda_oen <= 1'b0;
                end
                bit_stop_b:
                begin
                    state   <= bit_stop_c;
                    scl_oen <= 1'b1;
                end
                bit_stop_c:
                begin
                    state   <= bit_stop_d;
                    sda_oen <= 1'b1;    // stop condition
                end
                bit_stop_d:
                begin
                    state   <= bit_idle;
                    bit_ack <= 1'b1;
                end
                bit_read_a:
                begin
                    state   <= bit_read_b;
                    scl_oen <= 1'b0;
                    sda_oen <= 1'b1;
                end
                bit_read_b:
                begin
                    state   <= bit_read_c;
                    scl_oen <= 1'b1;
                end
                bit_read_c:
                    state <= bit_read_d;
                bit_read_d:
                begin
                    state   <= bit_idle;
                    scl_oen <= 1'b0;
                    bit_ack <= 1'b1;
                end
                bit_write_a:
                begin
                    state   <= bit_write_b;
                    scl_oen <= 1'b0;
                    sda_oen <= bit_din;
                end
                bit_write_b:
                begin
                    state   <= bit_write_c;
                    scl_oen <= 1'b1;
                end
                bit_write_c:
                begin
                    state   <= bit_write_d;
                    sda_chk <= 1'b1;
                end
                bit_write_d:
                begin
                    state   <= bit_idle;
                    scl_oen <= 1'b0;
                    bit_ack <= 1'b1;
                end
                bit_restart_a:
                begin
                    state   <= bit_restart_b;
                    scl_oen <= 1'b0;
                    sda_oen <= 1'b1;
                end
                bit_restart_b:
                begin
                    state   <= bit_restart_c;
                    scl_oen <= 1'b1;
                end
                bit_restart_c:
                begin
                    state   <= bit_restart_d;
                    sda_oen <= 1'b0;    // repeated start
                end
                bit_restart_d:
                begin
                    state   <= bit_idle;
                    scl_oen <= 1'b0;
                    bit_ack <= 1'b1;
                end
                default:
                    state <= bit_idle;
            endcase
        end
    end
end

endmodule

/* hw/i2c_pkg.sv */
package i2c_pkg;

    typedef logic [15:0] prescale_t;   // sysclk cycles per scl period
    typedef logic [7:0]  i2c_byte_t;
    typedef logic [2:0]  bit_cnt_t;    // data bit index

    localparam prescale_t prescale_reset = 16'd192;

    typedef enum logic [2:0] {
        cmd_idle,
        cmd_start,
        cmd_stop,
        cmd_write,
        cmd_read,
        cmd_restart
    } bit_cmd_e;

    typedef enum logic [4:0] {
        bit_idle,
        bit_start_a, bit_start_b, bit_start_c, bit_start_d, bit_start_e,
        bit_stop_a, bit_stop_b, bit_stop_c, bit_stop_d,
        bit_read_a, bit_read_b, bit_read_c, bit_read_d,
        bit_write_a, bit_write_b, bit_write_c, bit_write_d,
        bit_restart_a, bit_restart_b, bit_restart_c, bit_restart_d
    } bit_state_e;

    typedef enum logic [2:0] {
        byte_idle,
        byte_start,
        byte_shift,
        byte_ack,
        byte_stop,
        byte_done
    } byte_state_e;

    typedef struct packed {
        logic      start;
        logic      stop;
        logic      read;
        logic      write;
        logic      ack_in;    // master ack after a read byte
        i2c_byte_t txd;
    } byte_cmd_t;

    typedef struct packed {
        logic      ack_out;
        i2c_byte_t rxd;
        logic      busy;
        logic      arblost;
    } byte_status_t;

endpackage
